// File: hdl/sysctrl_pkg.sv
// system control shared definitions
package sysctrl_pkg;

  // mcu command codes
  localparam logic [7:0] CMD_STATUS  = 8'd0;
  localparam logic [7:0] CMD_LEDS    = 8'd1;
  localparam logic [7:0] CMD_COLOR   = 8'd2;
  localparam logic [7:0] CMD_BUTTONS = 8'd3;
  localparam logic [7:0] CMD_SETTING = 8'd4;
  localparam logic [7:0] CMD_IRQ     = 8'd5;
  localparam logic [7:0] CMD_IRQ_SRC = 8'd6;
  localparam logic [7:0] CMD_PORT_RD = 8'd7;
  localparam logic [7:0] CMD_PORT_WR = 8'd8;

  // setting ids consumed by the boot timer
  localparam logic [7:0] ID_RESET       = "R";
  localparam logic [7:0] ID_DRIVE_RESET = "Z";

  // setting ids for the osd record
  localparam logic [7:0] ID_REU_CFG       = "V";
  localparam logic [7:0] ID_SCANLINES     = "S";
  localparam logic [7:0] ID_VOLUME        = "A";
  localparam logic [7:0] ID_WIDE_SCREEN   = "W";
  localparam logic [7:0] ID_FLOPPY_WPROT  = "P";
  localparam logic [7:0] ID_PORT_1        = "Q";
  localparam logic [7:0] ID_PORT_2        = "J";
  localparam logic [7:0] ID_DOS_SEL       = "D";
  localparam logic [7:0] ID_SID_DIGIFIX   = "U";
  localparam logic [7:0] ID_TURBO_MODE    = "X";
  localparam logic [7:0] ID_TURBO_SPEED   = "Y";
  localparam logic [7:0] ID_VIDEO_STD     = "E";
  localparam logic [7:0] ID_MIDI          = "N";
  localparam logic [7:0] ID_PAUSE         = "G";
  localparam logic [7:0] ID_VIC_VARIANT   = "M";
  localparam logic [7:0] ID_CIA_MODE      = "C";
  localparam logic [7:0] ID_SID_VER       = "O";
  localparam logic [7:0] ID_SID_MODE      = "K";
  localparam logic [7:0] ID_TAPE_SOUND    = "I";
  localparam logic [7:0] ID_UP9600        = "<";
  localparam logic [7:0] ID_SID_FILTER    = "H";
  localparam logic [7:0] ID_SID_FC_OFFSET = ">";
  localparam logic [7:0] ID_GEORAM        = "#";
  localparam logic [7:0] ID_UART          = "*";
  localparam logic [7:0] ID_JOYSWAP       = "&";
  localparam logic [7:0] ID_DETACH_RESET  = "F";

  // one data byte of an open transfer
  typedef struct packed {
    logic       valid;
    logic [7:0] cmd;
    logic [3:0] index;
    logic [7:0] data;
  } mcu_beat_t;

  // read byte offered during a beat
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } rd_resp_t;

  // id keyed settings write
  typedef struct packed {
    logic       valid;
    logic [7:0] id;
    logic [7:0] value;
  } setting_wr_t;

  // osd settings record
  typedef struct packed {
    logic       reu_cfg;
    logic [1:0] scanlines;
    logic [1:0] volume;
    logic       wide_screen;
    logic [1:0] floppy_wprot;
    logic [3:0] port_1;
    logic [3:0] port_2;
    logic [1:0] dos_sel;
    logic       sid_digifix;
    logic [1:0] turbo_mode;
    logic [1:0] turbo_speed;
    logic       video_std;
    logic [2:0] midi;
    logic       pause;
    logic [1:0] vic_variant;
    logic       cia_mode;
    logic [2:0] sid_mode;
    logic       sid_ver;
    logic       tape_sound;
    logic [2:0] up9600;
    logic [2:0] sid_filter;
    logic [2:0] sid_fc_offset;
    logic       georam;
    logic [1:0] uart;
    logic       joyswap;
    logic       detach_reset;
  } sys_cfg_t;

  // sane defaults until the mcu sends its own
  // volume at 66%, port 1 off
  localparam sys_cfg_t CFG_DEFAULTS = '{volume: 2'd2, port_1: 4'd7, default: '0};

  // dim colour when no mcu answered in time
  localparam logic [23:0] COLOR_NO_MCU = 24'h000202;

  // status signature, unlikely on a blank device
  localparam logic [7:0] STATUS_SIG0 = 8'h5c;
  localparam logic [7:0] STATUS_SIG1 = 8'h42;

endpackage

// File: hdl/mcu_frame_decoder.sv
// mcu byte link framing
`timescale 1ns/1ps

module mcu_frame_decoder #(
  parameter logic [7:0] CORE_ID = 8'd2
) (
  input  logic                  clk,
  input  logic                  main_reset_timeout,
  input  logic                  data_in_strobe_i,
  input  logic                  data_in_start_i,
  input  logic [7:0]            data_in_i,
  input  logic [1:0]            buttons_i,
  input  sysctrl_pkg::rd_resp_t irq_rd_i,
  input  sysctrl_pkg::rd_resp_t port_rd_i,
  output sysctrl_pkg::mcu_beat_t beat_o,
  output logic [7:0]            data_out_o
);

  // current command and byte index, 0 means no open transfer
  logic [7:0] cmd_q;
  logic [3:0] index_q;

  sysctrl_pkg::mcu_beat_t beat;
  sysctrl_pkg::rd_resp_t  own_rd;

  // data byte of an open transfer becomes a beat
  always_comb begin
    beat.valid = data_in_strobe_i && !data_in_start_i && (index_q != 4'd0);
    beat.cmd   = cmd_q;
    beat.index = index_q;
    beat.data  = data_in_i;
  end

  assign beat_o = beat;

  // framing, the index saturates at 15
  always_ff @(posedge clk) begin
    if (main_reset_timeout) begin
      cmd_q   <= 8'd0;
      index_q <= 4'd0;
    end else if (data_in_strobe_i && data_in_start_i) begin
      cmd_q   <= data_in_i;
      index_q <= 4'd1;
    end else if (beat.valid && index_q != 4'd15) begin
      index_q <= index_q + 4'd1;
    end
  end

  // own answers: status signature and buttons
  always_comb begin
    own_rd.valid = 1'b0;
    own_rd.data  = 8'h00;
    if (beat.valid) begin
      if (beat.cmd == sysctrl_pkg::CMD_STATUS) begin
        own_rd.valid = (beat.index >= 4'd1) && (beat.index <= 4'd3);
        case (beat.index)
          4'd1:    own_rd.data = sysctrl_pkg::STATUS_SIG0;
          4'd2:    own_rd.data = sysctrl_pkg::STATUS_SIG1;
          4'd3:    own_rd.data = CORE_ID;
          default: own_rd.data = 8'h00;
        endcase
      end else if (beat.cmd == sysctrl_pkg::CMD_BUTTONS) begin
        // buttons answer at any index
        own_rd.valid = 1'b1;
        own_rd.data  = {6'b000000, buttons_i};
      end
    end
  end

  // response byte, held until the next one
  always_ff @(posedge clk) begin
    if (own_rd.valid) begin
      data_out_o <= own_rd.data;
    end else if (irq_rd_i.valid) begin
      data_out_o <= irq_rd_i.data;
    end else if (port_rd_i.valid) begin
      data_out_o <= port_rd_i.data;
    end
  end

  // the mcu must see the same byte between its strobes
  a_data_out_hold: assert property (@(posedge clk) disable iff (main_reset_timeout)
    !beat.valid |=> $stable(data_out_o));

endmodule

// File: hdl/settings_regs.sv
// leds, colour and osd settings
`timescale 1ns/1ps

module settings_regs (
  input  logic                    clk,
  input  logic                    main_reset_timeout,
  input  sysctrl_pkg::mcu_beat_t  beat_i,
  input  logic                    hold_expired_i,
  output logic [1:0]              leds_o,
  output logic [23:0]             color_o,
  output sysctrl_pkg::sys_cfg_t   cfg_o,
  output sysctrl_pkg::setting_wr_t setting_wr_o
);

  // id byte of the setting in flight
  logic [7:0] id_q;
  logic [7:0] rev_data;

  sysctrl_pkg::setting_wr_t wr;

  // colour bytes arrive lsb first
  function automatic logic [7:0] rev8(input logic [7:0] b);
    logic [7:0] r;
    for (int i = 0; i < 8; i++) begin
      r[i] = b[7-i];
    end
    return r;
  endfunction

  assign rev_data = rev8(beat_i.data);

  // second data byte of a settings command carries the value
  always_comb begin
    wr.valid = beat_i.valid && beat_i.cmd == sysctrl_pkg::CMD_SETTING && beat_i.index == 4'd2;
    wr.id    = id_q;
    wr.value = beat_i.data;
  end

  assign setting_wr_o = wr;

  always_ff @(posedge clk) begin
    if (beat_i.valid && beat_i.cmd == sysctrl_pkg::CMD_SETTING && beat_i.index == 4'd1) begin
      id_q <= beat_i.data;
    end
  end

  always_ff @(posedge clk) begin
    if (main_reset_timeout) begin
      // leds off and rgb led dark
      leds_o  <= 2'b00;
      color_o <= 24'h000000;
      cfg_o   <= sysctrl_pkg::CFG_DEFAULTS;
    end else begin
      // no mcu took over the boot hold
      if (hold_expired_i) color_o <= sysctrl_pkg::COLOR_NO_MCU;

      if (beat_i.valid && beat_i.cmd == sysctrl_pkg::CMD_LEDS && beat_i.index == 4'd1) begin
        leds_o <= beat_i.data[1:0];
      end

      // wire order is G, B, R
      if (beat_i.valid && beat_i.cmd == sysctrl_pkg::CMD_COLOR) begin
        if (beat_i.index == 4'd1) color_o[15:8]  <= rev_data;
        if (beat_i.index == 4'd2) color_o[7:0]   <= rev_data;
        if (beat_i.index == 4'd3) color_o[23:16] <= rev_data;
      end

      // reset ids belong to the boot timer and fall through
      if (wr.valid) begin
        case (wr.id)
          sysctrl_pkg::ID_REU_CFG:       cfg_o.reu_cfg       <= wr.value[0];
          sysctrl_pkg::ID_SCANLINES:     cfg_o.scanlines     <= wr.value[1:0];
          sysctrl_pkg::ID_VOLUME:        cfg_o.volume        <= wr.value[1:0];
          sysctrl_pkg::ID_WIDE_SCREEN:   cfg_o.wide_screen   <= wr.value[0];
          sysctrl_pkg::ID_FLOPPY_WPROT:  cfg_o.floppy_wprot  <= wr.value[1:0];
          sysctrl_pkg::ID_PORT_1:        cfg_o.port_1        <= wr.value[3:0];
          sysctrl_pkg::ID_PORT_2:        cfg_o.port_2        <= wr.value[3:0];
          sysctrl_pkg::ID_DOS_SEL:       cfg_o.dos_sel       <= wr.value[1:0];
          sysctrl_pkg::ID_SID_DIGIFIX:   cfg_o.sid_digifix   <= wr.value[0];
          sysctrl_pkg::ID_TURBO_MODE:    cfg_o.turbo_mode    <= wr.value[1:0];
          sysctrl_pkg::ID_TURBO_SPEED:   cfg_o.turbo_speed   <= wr.value[1:0];
          sysctrl_pkg::ID_VIDEO_STD:     cfg_o.video_std     <= wr.value[0];
          sysctrl_pkg::ID_MIDI:          cfg_o.midi          <= wr.value[2:0];
          sysctrl_pkg::ID_PAUSE:         cfg_o.pause         <= wr.value[0];
          sysctrl_pkg::ID_VIC_VARIANT:   cfg_o.vic_variant   <= wr.value[1:0];
          sysctrl_pkg::ID_CIA_MODE:      cfg_o.cia_mode      <= wr.value[0];
          sysctrl_pkg::ID_SID_VER:       cfg_o.sid_ver       <= wr.value[0];
          sysctrl_pkg::ID_SID_MODE:      cfg_o.sid_mode      <= wr.value[2:0];
          sysctrl_pkg::ID_TAPE_SOUND:    cfg_o.tape_sound    <= wr.value[0];
          sysctrl_pkg::ID_UP9600:        cfg_o.up9600        <= wr.value[2:0];
          sysctrl_pkg::ID_SID_FILTER:    cfg_o.sid_filter    <= wr.value[2:0];
          sysctrl_pkg::ID_SID_FC_OFFSET: cfg_o.sid_fc_offset <= wr.value[2:0];
          sysctrl_pkg::ID_GEORAM:        cfg_o.georam        <= wr.value[0];
          sysctrl_pkg::ID_UART:          cfg_o.uart          <= wr.value[1:0];
          sysctrl_pkg::ID_JOYSWAP:       cfg_o.joyswap       <= wr.value[0];
          sysctrl_pkg::ID_DETACH_RESET:  cfg_o.detach_reset  <= wr.value[0];
          default: ;
        endcase
      end
    end
  end

  // a settings write lasts one cycle since the index moves on after the value byte
  a_wr_pulse: assert property (@(posedge clk) disable iff (main_reset_timeout)
    setting_wr_o.valid |=> !setting_wr_o.valid);

endmodule

// File: hdl/boot_reset_timer.sv
// power-on reset hold
`timescale 1ns/1ps

module boot_reset_timer #(
  parameter logic [31:0] BOOT_HOLD_CYCLES = 32'd80_000_000
) (
  input  logic                     clk,
  input  logic                     main_reset_timeout,
  input  sysctrl_pkg::setting_wr_t setting_wr_i,
  output logic [1:0]               system_reset_o,
  output logic                     drive_reset_o,
  output logic                     hold_expired_o
);

  // zero once expired or once the mcu took over
  logic [31:0] hold_count;

  // last cycle of the hold, same edge as the release
  assign hold_expired_o = (hold_count == 32'd1);

  always_ff @(posedge clk) begin
    if (main_reset_timeout) begin
      // machine in cold boot, drive held too
      system_reset_o <= 2'd3;
      drive_reset_o  <= 1'b1;
      hold_count     <= BOOT_HOLD_CYCLES;
    end else begin
      if (hold_count != 32'd0) begin
        hold_count <= hold_count - 32'd1;
        if (hold_expired_o) begin
          system_reset_o <= 2'd0;
          drive_reset_o  <= 1'b0;
        end
      end

      // mcu writes win over the countdown
      // coldboot(3), reset(1) or run(0)
      if (setting_wr_i.valid && setting_wr_i.id == sysctrl_pkg::ID_RESET) begin
        system_reset_o <= setting_wr_i.value[1:0];
        hold_count     <= 32'd0;
      end
      if (setting_wr_i.valid && setting_wr_i.id == sysctrl_pkg::ID_DRIVE_RESET) begin
        drive_reset_o <= setting_wr_i.value[0];
      end
    end
  end

endmodule

// File: hdl/irq_ctrl.sv
// mcu interrupt control
`timescale 1ns/1ps

module irq_ctrl (
  input  logic                   clk,
  input  logic                   main_reset_timeout,
  input  sysctrl_pkg::mcu_beat_t beat_i,
  input  logic [7:0]             int_in_i,
  input  logic                   port_out_available_i,
  output sysctrl_pkg::rd_resp_t  rd_o,
  output logic [7:0]             int_ack_o,
  output logic                   int_out_n_o,
  output logic                   cold_boot_o
);

  // system interrupt raised on cold boot and new port data
  logic sys_int;
  // availability delay register and its previous value
  logic avail_d;
  logic avail_dd;
  logic is_irq;
  logic is_src;

  assign is_irq = beat_i.valid && beat_i.cmd == sysctrl_pkg::CMD_IRQ;
  assign is_src = beat_i.valid && beat_i.cmd == sysctrl_pkg::CMD_IRQ_SRC;

  // line is low while anything is pending
  assign int_out_n_o = !((int_in_i != 8'h00) || sys_int);

  // irq returns the pending sources with our own in bit 0
  // irq_src returns port data in bit 1 and cold boot in bit 0
  always_comb begin
    rd_o.valid = is_irq || is_src;
    if (is_irq) rd_o.data = {int_in_i[7:1], sys_int};
    else        rd_o.data = {6'b000000, port_out_available_i, cold_boot_o};
  end

  always_ff @(posedge clk) begin
    if (main_reset_timeout) begin
      int_ack_o   <= 8'h00;
      sys_int     <= 1'b1;
      cold_boot_o <= 1'b1;
      avail_d     <= 1'b0;
      avail_dd    <= 1'b0;
    end else begin
      int_ack_o <= 8'h00;
      avail_d   <= port_out_available_i;
      avail_dd  <= avail_d;
      // ack bit 0 retires the system interrupt
      if (int_ack_o[0]) sys_int <= 1'b0;
      // fresh port data outranks a pending ack
      if (avail_d && !avail_dd) sys_int <= 1'b1;
      if (is_irq && beat_i.index == 4'd1) int_ack_o <= beat_i.data;
      // reading the source retires the cold boot notice
      if (is_src && beat_i.index == 4'd1) cold_boot_o <= 1'b0;
    end
  end

  a_ack_pulse: assert property (@(posedge clk) disable iff (main_reset_timeout)
    (int_ack_o != 8'h00) |=> (int_ack_o == 8'h00));

endmodule

// File: hdl/port_bridge.sv
// external byte port bridge
`timescale 1ns/1ps

module port_bridge (
  input  logic                   clk,
  input  logic                   main_reset_timeout,
  input  sysctrl_pkg::mcu_beat_t beat_i,
  input  logic                   port_out_available_i,
  input  logic [7:0]             port_out_data_i,
  output sysctrl_pkg::rd_resp_t  rd_o,
  output logic                   port_out_strobe_o,
  output logic                   port_in_strobe_o,
  output logic [7:0]             port_in_data_o
);

  // byte captured at the availability read
  logic [7:0] rd_latch;
  logic       is_rd;
  logic       is_wr;

  assign is_rd = beat_i.valid && beat_i.cmd == sysctrl_pkg::CMD_PORT_RD;
  assign is_wr = beat_i.valid && beat_i.cmd == sysctrl_pkg::CMD_PORT_WR && beat_i.index == 4'd1;

  // first byte is the flag, second the latched data
  always_comb begin
    rd_o.valid = is_rd && (beat_i.index == 4'd1 || beat_i.index == 4'd2);
    if (beat_i.index == 4'd1) rd_o.data = {7'd0, port_out_available_i};
    else                      rd_o.data = rd_latch;
  end

  // data may arrive between the two reads, so pop only what was flagged
  always_ff @(posedge clk) begin
    if (is_rd && beat_i.index == 4'd1) rd_latch <= port_out_data_i;
    if (is_wr) port_in_data_o <= beat_i.data;
  end

  always_ff @(posedge clk) begin
    if (main_reset_timeout) begin
      port_out_strobe_o <= 1'b0;
      port_in_strobe_o  <= 1'b0;
    end else begin
      port_out_strobe_o <= is_rd && beat_i.index == 4'd1 && port_out_available_i;
      port_in_strobe_o  <= is_wr;
    end
  end

  a_one_pop: assert property (@(posedge clk) disable iff (main_reset_timeout)
    port_out_strobe_o |=> !port_out_strobe_o);

endmodule

// File: hdl/sysctrl_top.sv
// system control top level
`timescale 1ns/1ps

module sysctrl_top #(
  parameter logic [31:0] BOOT_HOLD_CYCLES = 32'd80_000_000,
  parameter logic [7:0]  CORE_ID          = 8'd2
) (
  input  logic                  clk,
  input  logic                  main_reset_timeout,
  // mcu link
  input  logic                  data_in_strobe_i,
  input  logic                  data_in_start_i,
  input  logic [7:0]            data_in_i,
  output logic [7:0]            data_out_o,
  // interrupts
  output logic                  int_out_n_o,
  input  logic [7:0]            int_in_i,
  output logic [7:0]            int_ack_o,
  // board io
  input  logic [1:0]            buttons_i,
  output logic [1:0]            leds_o,
  output logic [23:0]           color_o,
  // byte port fifo
  output logic                  port_out_strobe_o,
  input  logic                  port_out_available_i,
  input  logic [7:0]            port_out_data_i,
  output logic                  port_in_strobe_o,
  output logic [7:0]            port_in_data_o,
  // machine control
  output sysctrl_pkg::sys_cfg_t cfg_o,
  output logic [1:0]            system_reset_o,
  output logic                  drive_reset_o,
  output logic                  cold_boot_o
);

  sysctrl_pkg::mcu_beat_t   beat;
  sysctrl_pkg::rd_resp_t    irq_rd;
  sysctrl_pkg::rd_resp_t    port_rd;
  sysctrl_pkg::setting_wr_t setting_wr;
  logic                     hold_expired;

  mcu_frame_decoder #(.CORE_ID(CORE_ID)) i_mcu_frame_decoder (
    .clk, .main_reset_timeout, .data_in_strobe_i, .data_in_start_i, .data_in_i,
    .buttons_i, .irq_rd_i(irq_rd), .port_rd_i(port_rd), .beat_o(beat), .data_out_o
  );

  settings_regs i_settings_regs (
    .clk, .main_reset_timeout, .beat_i(beat), .hold_expired_i(hold_expired),
    .leds_o, .color_o, .cfg_o, .setting_wr_o(setting_wr)
  );

  boot_reset_timer #(.BOOT_HOLD_CYCLES(BOOT_HOLD_CYCLES)) i_boot_reset_timer (
    .clk, .main_reset_timeout, .setting_wr_i(setting_wr),
    .system_reset_o, .drive_reset_o, .hold_expired_o(hold_expired)
  );

  irq_ctrl i_irq_ctrl (
    .clk, .main_reset_timeout, .beat_i(beat), .int_in_i, .port_out_available_i,
    .rd_o(irq_rd), .int_ack_o, .int_out_n_o, .cold_boot_o
  );

  port_bridge i_port_bridge (
    .clk, .main_reset_timeout, .beat_i(beat), .port_out_available_i, .port_out_data_i,
    .rd_o(port_rd), .port_out_strobe_o, .port_in_strobe_o, .port_in_data_o
  );

endmodule

// File: tests/sysctrl_tb.sv
// system control testbench
`timescale 1ns/1ps

module sysctrl_tb;

  localparam int HOLD_CYCLES = 300;
  localparam int TEST_CYCLES = 3000;
  localparam int CLK_PERIOD  = 20;

  logic                  clk;
  logic                  main_reset_timeout;
  logic                  data_in_strobe_i;
  logic                  data_in_start_i;
  logic [7:0]            data_in_i;
  logic [7:0]            data_out_o;
  logic                  int_out_n_o;
  logic [7:0]            int_in_i;
  logic [7:0]            int_ack_o;
  logic [1:0]            buttons_i;
  logic [1:0]            leds_o;
  logic [23:0]           color_o;
  logic                  port_out_strobe_o;
  logic                  port_out_available_i;
  logic [7:0]            port_out_data_i;
  logic                  port_in_strobe_o;
  logic [7:0]            port_in_data_o;
  sysctrl_pkg::sys_cfg_t cfg_o;
  logic [1:0]            system_reset_o;
  logic                  drive_reset_o;
  logic                  cold_boot_o;

  // scoreboard and monitor state
  int unsigned           errors;
  int unsigned           checks;
  int unsigned           cyc;
  int unsigned           out_pops;
  int unsigned           in_pushes;
  int unsigned           ack_pulses;
  int unsigned           seen;
  logic [7:0]            last_ack;
  logic [31:0]           rnd;
  logic [7:0]            val;
  logic [7:0]            held;
  logic [23:0]           rgb;
  sysctrl_pkg::sys_cfg_t cfg_before;

  sysctrl_top #(.BOOT_HOLD_CYCLES(32'(HOLD_CYCLES)), .CORE_ID(8'd2)) i_sysctrl_top (
    .clk(clk), .main_reset_timeout(main_reset_timeout),
    .data_in_strobe_i(data_in_strobe_i), .data_in_start_i(data_in_start_i),
    .data_in_i(data_in_i), .data_out_o(data_out_o),
    .int_out_n_o(int_out_n_o), .int_in_i(int_in_i), .int_ack_o(int_ack_o),
    .buttons_i(buttons_i), .leds_o(leds_o), .color_o(color_o),
    .port_out_strobe_o(port_out_strobe_o), .port_out_available_i(port_out_available_i),
    .port_out_data_i(port_out_data_i), .port_in_strobe_o(port_in_strobe_o),
    .port_in_data_o(port_in_data_o), .cfg_o(cfg_o), .system_reset_o(system_reset_o),
    .drive_reset_o(drive_reset_o), .cold_boot_o(cold_boot_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // cycles since reset release
  always @(posedge clk) begin
    if (main_reset_timeout) cyc <= 0;
    else cyc <= cyc + 1;
  end

  // pulse counters sampled away from the active edge
  always @(negedge clk) begin
    if (port_out_strobe_o) out_pops++;
    if (port_in_strobe_o) in_pushes++;
    if (int_ack_o != 8'h00) begin
      ack_pulses++;
      last_ack = int_ack_o;
    end
  end

  // run limit covers the boot hold plus all tests
  initial begin
    #((HOLD_CYCLES + TEST_CYCLES) * CLK_PERIOD);
    $display("watchdog expired before the tests completed");
    $display("TEST FAIL");
    $finish;
  end

  task automatic expect_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  function automatic logic [7:0] flip_byte(input logic [7:0] b);
    logic [7:0] r;
    for (int i = 0; i < 8; i++) begin
      r[7-i] = b[i];
    end
    return r;
  endfunction

  task automatic apply_reset();
    main_reset_timeout = 1'b1;
    repeat (3) @(negedge clk);
    main_reset_timeout = 1'b0;
  endtask

  // one strobe followed by an idle gap
  task automatic mcu_strobe(input logic start, input logic [7:0] b);
    data_in_strobe_i = 1'b1;
    data_in_start_i  = start;
    data_in_i        = b;
    @(negedge clk);
    data_in_strobe_i = 1'b0;
    data_in_start_i  = 1'b0;
    @(negedge clk);
  endtask

  task automatic write_setting(input logic [7:0] id, input logic [7:0] value);
    mcu_strobe(1'b1, sysctrl_pkg::CMD_SETTING);
    mcu_strobe(1'b0, id);
    mcu_strobe(1'b0, value);
  endtask

  task automatic wait_cycle(input int unsigned n);
    while (cyc < n) @(negedge clk);
  endtask

  initial begin
    rnd = $urandom(37);
    errors = 0;
    checks = 0;
    out_pops = 0;
    in_pushes = 0;
    ack_pulses = 0;
    last_ack = 8'h00;
    main_reset_timeout = 1'b1;
    data_in_strobe_i = 1'b0;
    data_in_start_i = 1'b0;
    data_in_i = 8'h00;
    int_in_i = 8'h00;
    buttons_i = 2'b00;
    port_out_available_i = 1'b0;
    port_out_data_i = 8'h00;
    apply_reset();

    // state right after reset
    expect_eq("reset_int_n", 64'd0, 64'(int_out_n_o));
    expect_eq("reset_leds", 64'd0, 64'(leds_o));
    expect_eq("reset_color", 64'd0, 64'(color_o));
    expect_eq("reset_strobes", 64'd0, 64'({port_out_strobe_o, port_in_strobe_o, int_ack_o}));

    // status signature and core id
    mcu_strobe(1'b1, sysctrl_pkg::CMD_STATUS);
    mcu_strobe(1'b0, 8'h00);
    expect_eq("status_sig0", 64'h5c, 64'(data_out_o));
    mcu_strobe(1'b0, 8'h00);
    expect_eq("status_sig1", 64'h42, 64'(data_out_o));
    mcu_strobe(1'b0, 8'h00);
    expect_eq("status_core_id", 64'h02, 64'(data_out_o));
    rnd = $urandom;
    buttons_i = rnd[1:0];
    mcu_strobe(1'b1, sysctrl_pkg::CMD_BUTTONS);
    mcu_strobe(1'b0, 8'h00);
    expect_eq("buttons", 64'(rnd[1:0]), 64'(data_out_o));

    // boot hold releases on cycle 300
    wait_cycle(HOLD_CYCLES - 1);
    expect_eq("hold_sys_reset", 64'd3, 64'(system_reset_o));
    expect_eq("hold_drive_reset", 64'd1, 64'(drive_reset_o));
    @(negedge clk);
    expect_eq("release_sys_reset", 64'd0, 64'(system_reset_o));
    expect_eq("release_drive_reset", 64'd0, 64'(drive_reset_o));
    expect_eq("no_mcu_color", 64'h000202, 64'(color_o));

    // leds and bit reversed colour sent as G B R
    rnd = $urandom;
    mcu_strobe(1'b1, sysctrl_pkg::CMD_LEDS);
    mcu_strobe(1'b0, rnd[7:0]);
    expect_eq("leds", 64'(rnd[1:0]), 64'(leds_o));
    rnd = $urandom;
    rgb = rnd[23:0];
    mcu_strobe(1'b1, sysctrl_pkg::CMD_COLOR);
    mcu_strobe(1'b0, flip_byte(rgb[15:8]));
    mcu_strobe(1'b0, flip_byte(rgb[7:0]));
    mcu_strobe(1'b0, flip_byte(rgb[23:16]));
    expect_eq("color", 64'(rgb), 64'(color_o));

    // id keyed settings land in their fields
    rnd = $urandom;
    write_setting(sysctrl_pkg::ID_VOLUME, rnd[7:0]);
    expect_eq("cfg_volume", 64'(rnd[1:0]), 64'(cfg_o.volume));
    rnd = $urandom;
    write_setting(sysctrl_pkg::ID_PORT_2, rnd[7:0]);
    expect_eq("cfg_port_2", 64'(rnd[3:0]), 64'(cfg_o.port_2));
    rnd = $urandom;
    write_setting(sysctrl_pkg::ID_MIDI, rnd[7:0]);
    expect_eq("cfg_midi", 64'(rnd[2:0]), 64'(cfg_o.midi));
    rnd = $urandom;
    write_setting(sysctrl_pkg::ID_JOYSWAP, rnd[7:0]);
    expect_eq("cfg_joyswap", 64'(rnd[0]), 64'(cfg_o.joyswap));
    rnd = $urandom;
    write_setting(sysctrl_pkg::ID_SID_FC_OFFSET, rnd[7:0]);
    expect_eq("cfg_sid_fc_offset", 64'(rnd[2:0]), 64'(cfg_o.sid_fc_offset));
    // '!' is not a known id
    cfg_before = cfg_o;
    rnd = $urandom;
    write_setting(8'h21, rnd[7:0]);
    expect_eq("cfg_unknown_id", 64'(cfg_before), 64'(cfg_o));

    // irq read with sys_int still set from boot
    rnd = $urandom;
    int_in_i = rnd[7:0] & 8'hfe;
    rnd = $urandom;
    val = rnd[7:0] | 8'h01;
    seen = ack_pulses;
    mcu_strobe(1'b1, sysctrl_pkg::CMD_IRQ);
    mcu_strobe(1'b0, val);
    expect_eq("irq_read", 64'(int_in_i | 8'h01), 64'(data_out_o));
    expect_eq("ack_pulses", 64'(seen + 1), 64'(ack_pulses));
    expect_eq("ack_value", 64'(val), 64'(last_ack));
    int_in_i = 8'h00;
    @(negedge clk);
    expect_eq("int_n_cleared", 64'd1, 64'(int_out_n_o));
    // source read retires cold boot
    mcu_strobe(1'b1, sysctrl_pkg::CMD_IRQ_SRC);
    mcu_strobe(1'b0, 8'h00);
    expect_eq("irq_src", 64'h01, 64'(data_out_o));
    expect_eq("cold_boot_cleared", 64'd0, 64'(cold_boot_o));
    // delay register first, then the set
    port_out_available_i = 1'b1;
    @(negedge clk);
    expect_eq("int_n_port_delay", 64'd1, 64'(int_out_n_o));
    @(negedge clk);
    expect_eq("int_n_port_edge", 64'd0, 64'(int_out_n_o));

    // port read with data waiting
    rnd = $urandom;
    port_out_data_i = rnd[7:0];
    held = rnd[7:0];
    seen = out_pops;
    mcu_strobe(1'b1, sysctrl_pkg::CMD_PORT_RD);
    mcu_strobe(1'b0, 8'h00);
    expect_eq("port_rd_flag", 64'd1, 64'(data_out_o));
    port_out_data_i = ~held;
    mcu_strobe(1'b0, 8'h00);
    expect_eq("port_rd_latch", 64'(held), 64'(data_out_o));
    expect_eq("port_rd_pops", 64'(seen + 1), 64'(out_pops));
    // nothing waiting so no pop
    port_out_available_i = 1'b0;
    seen = out_pops;
    mcu_strobe(1'b1, sysctrl_pkg::CMD_PORT_RD);
    mcu_strobe(1'b0, 8'h00);
    expect_eq("port_rd_empty", 64'd0, 64'(data_out_o));
    expect_eq("port_rd_no_pop", 64'(seen), 64'(out_pops));
    // port write
    rnd = $urandom;
    seen = in_pushes;
    mcu_strobe(1'b1, sysctrl_pkg::CMD_PORT_WR);
    mcu_strobe(1'b0, rnd[7:0]);
    expect_eq("port_wr_pushes", 64'(seen + 1), 64'(in_pushes));
    expect_eq("port_wr_data", 64'(rnd[7:0]), 64'(port_in_data_o));

    // second segment where the mcu takes over the boot hold
    apply_reset();
    held = data_out_o;
    // stray bytes reach the status answers if the closed transfer opens
    repeat (3) begin
      rnd = $urandom;
      mcu_strobe(1'b0, rnd[7:0]);
    end
    expect_eq("no_open_transfer", 64'(held), 64'(data_out_o));
    write_setting(sysctrl_pkg::ID_RESET, 8'h01);
    wait_cycle(HOLD_CYCLES + 10);
    expect_eq("mcu_sys_reset", 64'd1, 64'(system_reset_o));
    expect_eq("mcu_drive_reset", 64'd1, 64'(drive_reset_o));
    expect_eq("mcu_color", 64'd0, 64'(color_o));

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: compile.f
hdl/sysctrl_pkg.sv
hdl/mcu_frame_decoder.sv
hdl/settings_regs.sv
hdl/boot_reset_timer.sv
hdl/irq_ctrl.sv
hdl/port_bridge.sv
hdl/sysctrl_top.sv
tests/sysctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the system control testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module sysctrl_tb -f compile.f -o sysctrl_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/sysctrl_sim)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1
